//--- ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Operand and result width of the execute slice.
`define EX_XLEN 64

// Shift-add iterations per multiply, one per multiplier bit.
`define EX_MUL_STEPS `EX_XLEN

`endif

//--- ex_pkg.sv
`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_MUL  = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic [31:0]         pc;
        logic [4:0]          rd;
        logic                rd_w_en;  // Low marks a bubble.
        alu_op_e             op;
        logic [`EX_XLEN-1:0] src1;
        logic [`EX_XLEN-1:0] src2;     // rs2 value or sign-extended immediate.
        logic                is_mul;
    } id_ex_t;

    typedef struct packed {
        logic [31:0]         pc;
        logic [4:0]          rd;
        logic [`EX_XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

//--- id_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module id_decode (
    input  logic [31:0]         inst,
    input  logic [31:0]         pc,
    input  logic [`EX_XLEN-1:0] rs1_val,
    input  logic [`EX_XLEN-1:0] rs2_val,
    output ex_pkg::id_ex_t      dec
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`EX_XLEN-1:0] imm_i;
    logic [`EX_XLEN-1:0] shamt;
    logic [`EX_XLEN-1:0] src2_sel;
    logic                legal;
    ex_pkg::alu_op_e     op_sel;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{(`EX_XLEN-12){inst[31]}}, inst[31:20]};
    assign shamt  = {{(`EX_XLEN-6){1'b0}}, inst[25:20]};  // RV64 6-bit shift amount.

    ////////////////////////////////////////////////////////////
    // OP and OP-IMM groups
    ////////////////////////////////////////////////////////////
    always_comb begin
        legal    = 1'b0;
        op_sel   = ex_pkg::ALU_ADD;
        src2_sel = rs2_val;
        if (opcode == OPC_OP) begin
            if (funct7 == 7'b0000001) begin
                legal  = (funct3 == 3'b000);  // Only MUL of the M group.
                op_sel = ex_pkg::ALU_MUL;
            end else if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                case (funct3)
                    3'b000: op_sel = funct7[5] ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
                    3'b001: op_sel = ex_pkg::ALU_SLL;
                    3'b010: op_sel = ex_pkg::ALU_SLT;
                    3'b011: op_sel = ex_pkg::ALU_SLTU;
                    3'b100: op_sel = ex_pkg::ALU_XOR;
                    3'b101: op_sel = funct7[5] ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                    3'b110: op_sel = ex_pkg::ALU_OR;
                    default: op_sel = ex_pkg::ALU_AND;
                endcase
                legal = !funct7[5] || funct3 == 3'b000 || funct3 == 3'b101;
            end
        end else if (opcode == OPC_OP_IMM) begin
            legal    = 1'b1;
            src2_sel = imm_i;
            case (funct3)
                3'b000: op_sel = ex_pkg::ALU_ADD;
                3'b001: begin
                    op_sel   = ex_pkg::ALU_SLL;
                    src2_sel = shamt;
                    legal    = (inst[31:26] == 6'b000000);
                end
                3'b010: op_sel = ex_pkg::ALU_SLT;
                3'b011: op_sel = ex_pkg::ALU_SLTU;
                3'b100: op_sel = ex_pkg::ALU_XOR;
                3'b101: begin
                    op_sel   = inst[30] ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
                    src2_sel = shamt;
                    legal    = ({inst[31], inst[29:26]} == 5'b00000);
                end
                3'b110: op_sel = ex_pkg::ALU_OR;
                default: op_sel = ex_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec.pc      = pc;
        dec.rd      = inst[11:7];
        dec.rd_w_en = legal;  // Unsupported encodings become bubbles.
        dec.op      = op_sel;
        dec.src1    = rs1_val;
        dec.src2    = src2_sel;
        dec.is_mul  = legal && op_sel == ex_pkg::ALU_MUL;
    end

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     exu_idle,
    input  logic     in_valid,
    input  logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    output logic     out_ready,
    output payload_t out_data
);

    logic wen;

    // Downstream can take the item only when the execute unit is idle.
    assign out_ready = in_ready & exu_idle;

    // Load into an empty stage, or refill as the held item leaves.
    assign wen = (in_valid & ~out_valid) | (out_ready & out_valid);

    ////////////////////////////////////////////////////////////
    // Valid and payload flops
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
            out_data  <= '0;  // Flush drops the item.
        end else if (wen) begin
            out_valid <= in_valid;
            out_data  <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- exu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module exu (
    input  logic           clk,
    input  logic           rst,
    input  logic           op_valid,
    input  ex_pkg::id_ex_t op,
    output logic           accept,
    output logic           idle,
    output logic           wb_valid,
    output ex_pkg::wb_t    wb
);

    localparam int CNT_W = $clog2(`EX_MUL_STEPS + 1);
    localparam int SH_W  = $clog2(`EX_XLEN);

    logic                fire;
    logic                alu_wr;
    logic                mul_start;
    logic                mul_last;
    logic                busy;
    logic [CNT_W-1:0]    mul_cnt;
    logic [`EX_XLEN-1:0] mcand;
    logic [`EX_XLEN-1:0] mplier;
    logic [`EX_XLEN-1:0] prod;
    logic [`EX_XLEN-1:0] prod_next;
    logic [31:0]         mul_pc;
    logic [4:0]          mul_rd;
    logic [`EX_XLEN-1:0] alu_res;
    logic [SH_W-1:0]     shamt;

    assign idle      = ~busy;
    assign accept    = idle;
    assign fire      = op_valid & idle;  // Hand-over from the stage register.
    assign alu_wr    = fire & op.rd_w_en & ~op.is_mul;
    assign mul_start = fire & op.rd_w_en & op.is_mul;
    assign mul_last  = busy && mul_cnt == CNT_W'(1);
    assign prod_next = mplier[0] ? prod + mcand : prod;
    assign shamt     = op.src2[SH_W-1:0];

    ////////////////////////////////////////////////////////////
    // Single-cycle ALU
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (op.op)
            ex_pkg::ALU_ADD:  alu_res = op.src1 + op.src2;
            ex_pkg::ALU_SUB:  alu_res = op.src1 - op.src2;
            ex_pkg::ALU_SLT:  alu_res = {{(`EX_XLEN-1){1'b0}}, $signed(op.src1) < $signed(op.src2)};
            ex_pkg::ALU_SLTU: alu_res = {{(`EX_XLEN-1){1'b0}}, op.src1 < op.src2};
            ex_pkg::ALU_AND:  alu_res = op.src1 & op.src2;
            ex_pkg::ALU_OR:   alu_res = op.src1 | op.src2;
            ex_pkg::ALU_XOR:  alu_res = op.src1 ^ op.src2;
            ex_pkg::ALU_SLL:  alu_res = op.src1 << shamt;
            ex_pkg::ALU_SRL:  alu_res = op.src1 >> shamt;
            ex_pkg::ALU_SRA:  alu_res = $unsigned($signed(op.src1) >>> shamt);
            default:          alu_res = '0;  // MUL goes through the multiplier.
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Multiplier control and writeback valid
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            mul_cnt  <= '0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_wr | mul_last;
            if (mul_start) begin
                busy    <= 1'b1;
                mul_cnt <= CNT_W'(`EX_MUL_STEPS);
            end else if (busy) begin
                mul_cnt <= mul_cnt - CNT_W'(1);
                if (mul_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Shift-add datapath, low half of the product only.
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= op.src1;
            mplier <= op.src2;
            prod   <= '0;
            mul_pc <= op.pc;
            mul_rd <= op.rd;
        end else if (busy) begin
            prod   <= prod_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
        if (alu_wr) begin
            wb.pc   <= op.pc;
            wb.rd   <= op.rd;
            wb.data <= (op.rd == 5'd0) ? '0 : alu_res;  // x0 reads as zero.
        end else if (mul_last) begin
            wb.pc   <= mul_pc;
            wb.rd   <= mul_rd;
            wb.data <= (mul_rd == 5'd0) ? '0 : prod_next;
        end
    end

endmodule

`default_nettype wire

//--- ex_slice_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module ex_slice_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                issue_valid,
    input  logic [31:0]         issue_inst,
    input  logic [31:0]         issue_pc,
    input  logic [`EX_XLEN-1:0] issue_rs1_val,
    input  logic [`EX_XLEN-1:0] issue_rs2_val,
    output logic                issue_ready,
    output logic                wb_valid,
    output ex_pkg::wb_t         wb
);

    ex_pkg::id_ex_t dec;
    ex_pkg::id_ex_t stage_data;
    logic           stage_valid;
    logic           exu_accept;
    logic           exu_idle;

    id_decode id_decode_i (
        .inst    (issue_inst),
        .pc      (issue_pc),
        .rs1_val (issue_rs1_val),
        .rs2_val (issue_rs2_val),
        .dec     (dec)
    );

    id_ex_reg #(
        .payload_t (ex_pkg::id_ex_t)
    ) id_ex_reg_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .exu_idle  (exu_idle),
        .in_valid  (issue_valid),
        .in_ready  (exu_accept),
        .in_data   (dec),
        .out_valid (stage_valid),
        .out_ready (issue_ready),  // Upstream sees the stage's downstream ready.
        .out_data  (stage_data)
    );

    exu exu_i (
        .clk      (clk),
        .rst      (rst),
        .op_valid (stage_valid),
        .op       (stage_data),
        .accept   (exu_accept),
        .idle     (exu_idle),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

endmodule

`default_nettype wire

//--- ex_slice_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ex_slice_chk (
    input wire logic           clk,
    input wire logic           rst,
    input wire logic           flush,
    input wire logic           stage_valid,
    input wire logic           stage_ready,
    input wire ex_pkg::id_ex_t stage_data,
    input wire logic           exu_idle,
    input wire logic           wb_valid
);

    int fail_cnt = 0;

    // A stalled item must not change under the execute unit.
    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        stage_valid && !stage_ready && !flush |=> $stable(stage_data))
        else begin
            fail_cnt++;
            $error("stage payload changed while held");
        end

    a_flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !stage_valid)
        else begin
            fail_cnt++;
            $error("stage still valid after flush");
        end

    // Writeback never stretches into a busy multiplier.
    a_wb_single: assert property (@(posedge clk) disable iff (rst)
        !exu_idle && $past(wb_valid) |-> !wb_valid)
        else begin
            fail_cnt++;
            $error("writeback held high during multiply");
        end

endmodule

bind ex_slice_top ex_slice_chk ex_slice_chk_i (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .stage_valid (stage_valid),
    .stage_ready (issue_ready),
    .stage_data  (stage_data),
    .exu_idle    (exu_idle),
    .wb_valid    (wb_valid)
);

`default_nettype wire

//--- tb_ex_slice.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_cfg.svh"

module tb_ex_slice;

    typedef struct packed {
        logic [31:0]         inst;
        logic [31:0]         pc;
        logic [`EX_XLEN-1:0] rs1;
        logic [`EX_XLEN-1:0] rs2;
        logic                flush;
        logic                exp_wb;
    } entry_t;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                issue_valid;
    logic [31:0]         issue_inst;
    logic [31:0]         issue_pc;
    logic [`EX_XLEN-1:0] issue_rs1_val;
    logic [`EX_XLEN-1:0] issue_rs2_val;
    logic                issue_ready;
    logic                wb_valid;
    ex_pkg::wb_t         wb;

    entry_t      table_q[$];
    ex_pkg::wb_t exp_q[$];
    logic        b2b_q[$];
    logic        wb_seen;
    logic [31:0] lfsr;
    logic [31:0] next_pc;
    int          mismatches;
    int          other_errors;
    int          cycle_cnt;
    int          cycle_limit;

    ex_slice_top ex_slice_top_i (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue_inst    (issue_inst),
        .issue_pc      (issue_pc),
        .issue_rs1_val (issue_rs1_val),
        .issue_rs2_val (issue_rs2_val),
        .issue_ready   (issue_ready),
        .wb_valid      (wb_valid),
        .wb            (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [`EX_XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[`EX_XLEN-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, 5'd1, f3, rd, 7'b0010011};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic fl, input logic exp_wb);
        entry_t e;
        e.inst   = inst;
        e.pc     = next_pc;
        draw_bits(`EX_XLEN, e.rs1);
        draw_bits(`EX_XLEN, e.rs2);
        e.flush  = fl;
        e.exp_wb = exp_wb;
        table_q.push_back(e);
        next_pc  = next_pc + 32'd4;
    endtask

    // Writeback value per the RV64I/M rules for the supported ops.
    function automatic ex_pkg::wb_t model_wb(input entry_t e);
        ex_pkg::wb_t         w;
        logic [6:0]          opc;
        logic [2:0]          f3;
        logic                alt;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic [5:0]          sh;
        logic [`EX_XLEN-1:0] r;
        opc = e.inst[6:0];
        f3  = e.inst[14:12];
        alt = e.inst[30];
        a   = e.rs1;
        b   = (opc == 7'b0010011) ? {{(`EX_XLEN-12){e.inst[31]}}, e.inst[31:20]} : e.rs2;
        sh  = (opc == 7'b0010011) ? e.inst[25:20] : b[5:0];
        if (opc == 7'b0110011 && e.inst[25]) begin
            r = a * b;  // Low half only.
        end else begin
            case (f3)
                3'd0: r = (opc == 7'b0110011 && alt) ? a - b : a + b;
                3'd1: r = a << sh;
                3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'd3: r = (a < b) ? 64'd1 : 64'd0;
                3'd4: r = a ^ b;
                3'd5: r = alt ? 64'($signed(a) >>> sh) : a >> sh;
                3'd6: r = a | b;
                default: r = a & b;
            endcase
        end
        if (e.inst[11:7] == 5'd0) begin
            r = '0;
        end
        w.pc   = e.pc;
        w.rd   = e.inst[11:7];
        w.data = r;
        return w;
    endfunction

    task automatic build_table();
        add_entry(r_inst(7'h00, 3'd0, 5'd1), 1'b0, 1'b1);   // add
        add_entry(r_inst(7'h20, 3'd0, 5'd2), 1'b0, 1'b1);   // sub
        add_entry(r_inst(7'h00, 3'd1, 5'd3), 1'b0, 1'b1);   // sll
        add_entry(r_inst(7'h00, 3'd2, 5'd4), 1'b0, 1'b1);   // slt
        add_entry(r_inst(7'h00, 3'd3, 5'd5), 1'b0, 1'b1);   // sltu
        add_entry(r_inst(7'h00, 3'd4, 5'd6), 1'b0, 1'b1);   // xor
        add_entry(r_inst(7'h00, 3'd5, 5'd7), 1'b0, 1'b1);   // srl
        add_entry(r_inst(7'h20, 3'd5, 5'd8), 1'b0, 1'b1);   // sra
        add_entry(r_inst(7'h00, 3'd6, 5'd9), 1'b0, 1'b1);   // or
        add_entry(r_inst(7'h00, 3'd7, 5'd10), 1'b0, 1'b1);  // and
        add_entry(i_inst(12'h8a5, 3'd0, 5'd11), 1'b0, 1'b1);
        add_entry(i_inst(12'hfff, 3'd2, 5'd12), 1'b0, 1'b1);
        add_entry(i_inst(12'h7ff, 3'd3, 5'd13), 1'b0, 1'b1);
        add_entry(i_inst(12'hf0f, 3'd4, 5'd14), 1'b0, 1'b1);
        add_entry(i_inst(12'h123, 3'd6, 5'd15), 1'b0, 1'b1);
        add_entry(i_inst(12'h800, 3'd7, 5'd16), 1'b0, 1'b1);
        add_entry(i_inst({6'b000000, 6'd13}, 3'd1, 5'd17), 1'b0, 1'b1);
        add_entry(i_inst({6'b000000, 6'd45}, 3'd5, 5'd18), 1'b0, 1'b1);
        add_entry(i_inst({6'b010000, 6'd7}, 3'd5, 5'd19), 1'b0, 1'b1);
        add_entry(r_inst(7'h01, 3'd0, 5'd20), 1'b0, 1'b1);  // mul
        add_entry(r_inst(7'h00, 3'd0, 5'd21), 1'b0, 1'b1);  // Waits behind the mul.
        add_entry(r_inst(7'h01, 3'd0, 5'd22), 1'b0, 1'b1);
        add_entry(r_inst(7'h20, 3'd0, 5'd23), 1'b1, 1'b0);  // Flushed while mul runs.
        add_entry(r_inst(7'h00, 3'd0, 5'd0), 1'b0, 1'b1);   // x0 gives zero.
        add_entry(32'h0000_3083, 1'b0, 1'b0);               // Load is unsupported.
        add_entry(r_inst(7'h00, 3'd4, 5'd24), 1'b0, 1'b1);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        entry_t e;
        logic   taken;
        int     waits;
        logic   is_alu;
        logic   prev_alu;
        logic   prev_mul;
        logic   mul_queued;
        rst           = 1'b1;
        flush         = 1'b0;
        issue_valid   = 1'b0;
        issue_inst    = '0;
        issue_pc      = '0;
        issue_rs1_val = '0;
        issue_rs2_val = '0;
        mismatches    = 0;
        other_errors  = 0;
        lfsr          = 32'd95;
        next_pc       = 32'h0000_1000;
        prev_alu      = 1'b0;
        prev_mul      = 1'b0;
        mul_queued    = 1'b0;
        build_table();
        cycle_limit = table_q.size() * (`EX_MUL_STEPS + 4) + 100;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            issue_valid   <= 1'b1;
            issue_inst    <= e.inst;
            issue_pc      <= e.pc;
            issue_rs1_val <= e.rs1;
            issue_rs2_val <= e.rs2;
            taken = 1'b0;
            waits = 0;
            while (!taken) begin
                @(negedge clk);
                // Stage loads when empty or when its item leaves.
                taken = !ex_slice_top_i.stage_valid || issue_ready;
                @(posedge clk);
                waits++;
            end
            is_alu = e.exp_wb && !(e.inst[6:0] == 7'b0110011 && e.inst[25]);
            // An issue behind a stalled MUL waits out every multiplier step.
            if (mul_queued && waits - 1 != `EX_MUL_STEPS) begin
                $display("CHECK FAILED issue_ready low cycles got %h exp %h",
                         waits - 1, `EX_MUL_STEPS);
                mismatches++;
            end
            if (e.exp_wb) begin
                exp_q.push_back(model_wb(e));
                b2b_q.push_back(is_alu && prev_alu && waits == 1);
            end
            mul_queued = is_alu && prev_mul && waits == 1;
            prev_alu   = is_alu;
            prev_mul   = e.exp_wb && !is_alu;
            if (e.flush) begin
                issue_valid <= 1'b0;
                flush       <= 1'b1;
                @(posedge clk);
                flush <= 1'b0;
            end
        end
        issue_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);  // Catch stray writebacks.
        $display("Errors: %0d mismatches, %0d other, %0d assertion", mismatches, other_errors,
                 ex_slice_top_i.ex_slice_chk_i.fail_cnt);
        if (mismatches == 0 && other_errors == 0 &&
            ex_slice_top_i.ex_slice_chk_i.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Writeback monitor
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        ex_pkg::wb_t w;
        logic        b2b;
        if (!rst && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("Writeback appeared with no instruction expected, pc %h", wb.pc);
                other_errors++;
            end else begin
                w   = exp_q.pop_front();
                b2b = b2b_q.pop_front();
                if (wb.pc != w.pc) begin
                    $display("CHECK FAILED wb.pc got %h exp %h", wb.pc, w.pc);
                    mismatches++;
                end
                if (wb.rd != w.rd) begin
                    $display("CHECK FAILED wb.rd got %h exp %h", wb.rd, w.rd);
                    mismatches++;
                end
                if (wb.data != w.data) begin
                    $display("CHECK FAILED wb.data got %h exp %h", wb.data, w.data);
                    mismatches++;
                end
                if (b2b && !wb_seen) begin
                    $display("Back-to-back ALU writeback came later than one cycle after the last");
                    other_errors++;
                end
            end
        end
        wb_seen = wb_valid;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, writebacks still missing", cycle_cnt);
            $display("Test failures found");
            $finish;
        end
    end

    initial cycle_cnt = 0;

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
ex_pkg.sv
id_decode.sv
id_ex_reg.sv
exu.sv
ex_slice_top.sv
ex_slice_chk.sv
tb_ex_slice.sv

//--- Makefile
TOP = tb_ex_slice

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
